// File: Bender.yml
package:
  name: core_mem

sources:
  - core_mem_pkg.sv
  - mem_sp.sv
  - wmem_port.sv
  - kv_cache_port.sv
  - read_return.sv
  - lbuf_fifo.sv
  - core_mem.sv
  - target: test
    files:
      - tb_core_mem.sv

// File: core_mem.sv
`timescale 1ns/1ps

module core_mem (
    input  logic                          clk,
    input  logic                          rstn,

    // GBUS and MAC-side channel
    input  core_mem_pkg::gbus_req_t       gbus,
    input  core_mem_pkg::cmem_req_t       cmem,
    output core_mem_pkg::beat_t           gbus_rd,

    // Core-to-core link
    input  logic                          clink_enable,
    input  core_mem_pkg::beat_t           clink_in,
    output core_mem_pkg::beat_t           clink_out,

    // LBUF toward the MAC array
    input  logic                          lbuf_ren,
    input  logic                          lbuf_reuse_ren,
    input  logic                          lbuf_reuse_rst,
    output core_mem_pkg::beat_t           lbuf_rd,
    output core_mem_pkg::lbuf_status_t    lbuf_stat
);

    core_mem_pkg::mem_rd_t wmem_rd;
    core_mem_pkg::mem_rd_t cache_rd;
    core_mem_pkg::beat_t   lbuf_push;

    // ==================================================
    // Memories
    // ==================================================
    wmem_port u_wmem_port (
        .clk  (clk),
        .rstn (rstn),
        .gbus (gbus),
        .cmem (cmem),
        .rd   (wmem_rd)
    );

    kv_cache_port u_kv_cache_port (
        .clk  (clk),
        .rstn (rstn),
        .gbus (gbus),
        .cmem (cmem),
        .rd   (cache_rd)
    );

    // ==================================================
    // Return paths and local buffer
    // ==================================================
    read_return u_read_return (
        .clk          (clk),
        .rstn         (rstn),
        .gbus_ren     (gbus.ren),
        .gbus_region  (gbus.addr.wmem.region),
        .cmem_ren     (cmem.ren),
        .cmem_region  (cmem.raddr.wmem.region),
        .wmem_rd      (wmem_rd),
        .cache_rd     (cache_rd),
        .clink_enable (clink_enable),
        .clink_in     (clink_in),
        .gbus_rd      (gbus_rd),
        .clink_out    (clink_out),
        .lbuf_push    (lbuf_push)
    );

    lbuf_fifo u_lbuf (
        .clk       (clk),
        .rstn      (rstn),
        .push      (lbuf_push),
        .ren       (lbuf_ren),
        .reuse_ren (lbuf_reuse_ren),
        .reuse_rst (lbuf_reuse_rst),
        .rd        (lbuf_rd),
        .stat      (lbuf_stat)
    );

endmodule

// File: core_mem_pkg.sv
package core_mem_pkg;

    // ==================================================
    // Widths and depths
    // ==================================================
    localparam int gbus_data_w  = 32;
    localparam int gbus_addr_w  = 12;   // Bit 11 picks the cache

    localparam int wmem_depth   = 256;
    localparam int wmem_addr_w  = 8;

    localparam int cache_depth  = 128;
    localparam int cache_addr_w = 7;

    localparam int lbuf_depth   = 16;
    localparam int lbuf_addr_w  = 4;    // Index only, wrap bit sits on top
    localparam int alert_depth  = 3;    // Free slots left when almost_full rises

    // ==================================================
    // Core address, two decodes of one word
    // ==================================================
    typedef struct packed {
        logic                   region;     // 0 for WMEM
        logic [2:0]             unused;
        logic [wmem_addr_w-1:0] idx;
    } wmem_addr_t;

    typedef struct packed {
        logic                    region;    // 1 for KV cache
        logic [3:0]              unused;
        logic [cache_addr_w-1:0] idx;
    } cache_addr_t;

    typedef union packed {
        wmem_addr_t  wmem;
        cache_addr_t cache;
    } core_addr_u;

    // ==================================================
    // Channel bundles
    // ==================================================
    typedef struct packed {
        core_addr_u             addr;
        logic                   wen;
        logic [gbus_data_w-1:0] wdata;
        logic                   ren;
    } gbus_req_t;

    typedef struct packed {
        core_addr_u             waddr;      // Region bit ignored on writes
        logic                   wen;
        logic [gbus_data_w-1:0] wdata;
        core_addr_u             raddr;
        logic                   ren;
    } cmem_req_t;

    typedef struct packed {
        logic [gbus_data_w-1:0] rdata;
        logic                   rvalid;
    } mem_rd_t;

    typedef struct packed {
        logic [gbus_data_w-1:0] data;
        logic                   valid;
    } beat_t;

    typedef struct packed {
        logic empty;
        logic reuse_empty;
        logic full;
        logic almost_full;
    } lbuf_status_t;

endpackage

// File: kv_cache_port.sv
`timescale 1ns/1ps

module kv_cache_port (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_mem_pkg::gbus_req_t   gbus,
    input  core_mem_pkg::cmem_req_t   cmem,
    output core_mem_pkg::mem_rd_t     rd
);

    logic                                  gbus_wr;
    logic                                  cmem_wr;
    logic                                  wen;
    logic [core_mem_pkg::cache_addr_w-1:0] waddr;
    logic [core_mem_pkg::gbus_data_w-1:0]  wdata;

    logic                                  gbus_hit;
    logic                                  cmem_hit;
    logic                                  ren;
    logic [core_mem_pkg::cache_addr_w-1:0] raddr;
    logic [core_mem_pkg::cache_addr_w-1:0] addr;
    logic [core_mem_pkg::gbus_data_w-1:0]  rdata;
    logic                                  rvalid_q;

    // ==================================================
    // Write side, MAC results beat GBUS uploads
    // ==================================================
    assign gbus_wr = gbus.wen && gbus.addr.cache.region;
    assign cmem_wr = cmem.wen;                  // CMEM writes land here always
    assign wen     = gbus_wr || cmem_wr;
    assign waddr   = cmem_wr ? cmem.waddr.cache.idx : gbus.addr.cache.idx;
    assign wdata   = cmem_wr ? cmem.wdata : gbus.wdata;

    // ==================================================
    // Read side, GBUS beats CMEM
    // ==================================================
    assign gbus_hit = gbus.ren && gbus.addr.cache.region;
    assign cmem_hit = cmem.ren && cmem.raddr.cache.region;
    assign ren      = gbus_hit || cmem_hit;
    assign raddr    = gbus_hit ? gbus.addr.cache.idx : cmem.raddr.cache.idx;

    assign addr = wen ? waddr : raddr;

    mem_sp #(
        .depth (core_mem_pkg::cache_depth)
    ) u_cache (
        .clk   (clk),
        .addr  (addr),
        .wen   (wen),
        .wdata (wdata),
        .ren   (ren),
        .rdata (rdata)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= ren;
        end
    end

    assign rd = '{rdata: rdata, rvalid: rvalid_q};

    // The losing CMEM read would vanish without a trace
    a_single_reader: assert property (
        @(posedge clk) disable iff (!rstn) !(gbus_hit && cmem_hit)
    ) else $error("kv_cache_port: GBUS and CMEM read the cache together");

endmodule

// File: lbuf_fifo.sv
`timescale 1ns/1ps

module lbuf_fifo (
    input  logic                          clk,
    input  logic                          rstn,
    input  core_mem_pkg::beat_t           push,
    input  logic                          ren,
    input  logic                          reuse_ren,
    input  logic                          reuse_rst,
    output core_mem_pkg::beat_t           rd,
    output core_mem_pkg::lbuf_status_t    stat
);

    logic [core_mem_pkg::gbus_data_w-1:0] mem [core_mem_pkg::lbuf_depth];

    // Pointers carry one wrap bit above the index
    logic [core_mem_pkg::lbuf_addr_w:0]   wptr;
    logic [core_mem_pkg::lbuf_addr_w:0]   rptr;
    logic [core_mem_pkg::lbuf_addr_w:0]   uptr;
    logic [core_mem_pkg::lbuf_addr_w:0]   occupancy;
    logic [core_mem_pkg::lbuf_addr_w-1:0] rd_idx;

    logic                                 empty;
    logic                                 reuse_empty;
    logic                                 full;
    logic                                 almost_full;

    logic                                 do_push;
    logic                                 do_read;
    logic                                 do_reuse;

    logic [core_mem_pkg::gbus_data_w-1:0] rd_data_q;
    logic                                 rd_valid_q;

    // ==================================================
    // Status
    // ==================================================
    assign occupancy   = wptr - rptr;
    assign empty       = (wptr == rptr);
    assign reuse_empty = (uptr == wptr);
    assign full        = (wptr[core_mem_pkg::lbuf_addr_w] != rptr[core_mem_pkg::lbuf_addr_w])
                      && (wptr[core_mem_pkg::lbuf_addr_w-1:0]
                          == rptr[core_mem_pkg::lbuf_addr_w-1:0]);
    assign almost_full = occupancy >= (core_mem_pkg::lbuf_depth - core_mem_pkg::alert_depth);

    assign stat = '{empty: empty, reuse_empty: reuse_empty, full: full,
                    almost_full: almost_full};

    assign do_push  = push.valid && !full;              // Overflow beat is lost
    assign do_read  = ren && !empty;
    assign do_reuse = reuse_ren && !reuse_empty;

    // ==================================================
    // Pointers
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr <= '0;
            rptr <= '0;
            uptr <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= rptr + 1'b1;
            end
            // Rewind for another pass over the activations
            if (reuse_rst) begin
                uptr <= rptr;
            end else if (do_read || do_reuse) begin
                uptr <= uptr + 1'b1;
            end
        end
    end

    // ==================================================
    // Storage and read port
    // ==================================================
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr[core_mem_pkg::lbuf_addr_w-1:0]] <= push.data;
        end
    end

    assign rd_idx = reuse_ren ? uptr[core_mem_pkg::lbuf_addr_w-1:0]
                              : rptr[core_mem_pkg::lbuf_addr_w-1:0];

    always_ff @(posedge clk) begin
        if (do_read || do_reuse) begin
            rd_data_q <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= do_read || do_reuse;
        end
    end

    assign rd = '{data: rd_data_q, valid: rd_valid_q};

    // One read pointer drives the port per cycle
    a_one_reader: assert property (
        @(posedge clk) disable iff (!rstn) !(ren && reuse_ren)
    ) else $error("lbuf_fifo: normal and reuse read together");

endmodule

// File: mem_sp.sv
`timescale 1ns/1ps

module mem_sp #(
    parameter int depth = 256
) (
    input  logic                                  clk,
    input  logic [$clog2(depth)-1:0]              addr,
    input  logic                                  wen,
    input  logic [core_mem_pkg::gbus_data_w-1:0]  wdata,
    input  logic                                  ren,
    output logic [core_mem_pkg::gbus_data_w-1:0]  rdata
);

    logic [core_mem_pkg::gbus_data_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
    end

    // Read port holds its last word between reads
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: read_return.sv
`timescale 1ns/1ps

module read_return (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      gbus_ren,
    input  logic                      gbus_region,
    input  logic                      cmem_ren,
    input  logic                      cmem_region,
    input  core_mem_pkg::mem_rd_t     wmem_rd,
    input  core_mem_pkg::mem_rd_t     cache_rd,
    input  logic                      clink_enable,
    input  core_mem_pkg::beat_t       clink_in,
    output core_mem_pkg::beat_t       gbus_rd,
    output core_mem_pkg::beat_t       clink_out,
    output core_mem_pkg::beat_t       lbuf_push
);

    logic                                 gbus_ren_q;
    logic                                 gbus_region_q;
    logic                                 cmem_ren_q;
    logic                                 cmem_region_q;
    logic [core_mem_pkg::gbus_data_w-1:0] nbr_data_q;
    logic                                 nbr_valid_q;

    core_mem_pkg::mem_rd_t                gbus_src;
    core_mem_pkg::mem_rd_t                cmem_src;
    logic                                 cmem_beat;
    logic                                 relay_valid;
    logic [core_mem_pkg::gbus_data_w-1:0] relay_data;

    // ==================================================
    // Strobe and region pipeline
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gbus_ren_q    <= 1'b0;
            gbus_region_q <= 1'b0;
            cmem_ren_q    <= 1'b0;
            cmem_region_q <= 1'b0;
            nbr_valid_q   <= 1'b0;
        end else begin
            gbus_ren_q    <= gbus_ren;
            gbus_region_q <= gbus_region;
            cmem_ren_q    <= cmem_ren;
            cmem_region_q <= cmem_region;
            nbr_valid_q   <= clink_in.valid;
        end
    end

    // Neighbor word
    always_ff @(posedge clk) begin
        if (clink_in.valid) begin
            nbr_data_q <= clink_in.data;
        end
    end

    // ==================================================
    // GBUS return
    // ==================================================
    assign gbus_src = gbus_region_q ? cache_rd : wmem_rd;
    assign gbus_rd  = '{data: gbus_src.rdata, valid: gbus_ren_q && gbus_src.rvalid};

    // ==================================================
    // CLINK relay and LBUF feed
    // ==================================================
    assign cmem_src  = cmem_region_q ? cache_rd : wmem_rd;
    assign cmem_beat = cmem_ren_q && cmem_src.rvalid;

    assign relay_valid = nbr_valid_q || cmem_beat;
    assign relay_data  = nbr_valid_q ? nbr_data_q : cmem_src.rdata;   // Neighbor first

    assign clink_out = '{data: relay_data, valid: clink_enable && relay_valid};
    assign lbuf_push = '{data: relay_data, valid: relay_valid};          // Not gated

    // Neighbor word would hide the memory beat on the relay
    a_no_beat_overlap: assert property (
        @(posedge clk) disable iff (!rstn) !(nbr_valid_q && cmem_ren_q)
    ) else $error("read_return: neighbor beat and CMEM beat in one cycle");

endmodule

// File: tb_core_mem.sv
`timescale 1ns/1ps

module tb_core_mem;

    typedef enum {OP_GWR, OP_GRD, OP_CWR, OP_COLL, OP_CRD, OP_NBR,
                  OP_LRD, OP_URD, OP_URST, OP_STAT} op_e;
    typedef enum {CHK_NONE, CHK_GBUS, CHK_CLINK, CHK_LBUF, CHK_STAT} chk_e;

    typedef struct {
        string                    name;
        op_e                      op;
        core_mem_pkg::core_addr_u addr;
        logic [31:0]              data;
        logic [31:0]              alt;        // GBUS word in a collision
        bit                       en;         // clink_enable for the beat
        chk_e                     chk;
        bit                       exp_valid;
        logic [31:0]              exp;
    } entry_t;

    logic                       clk;
    logic                       rstn;
    core_mem_pkg::gbus_req_t    gbus;
    core_mem_pkg::cmem_req_t    cmem;
    logic                       clink_enable;
    core_mem_pkg::beat_t        clink_in;
    logic                       lbuf_ren;
    logic                       lbuf_reuse_ren;
    logic                       lbuf_reuse_rst;
    core_mem_pkg::beat_t        gbus_rd;
    core_mem_pkg::beat_t        clink_out;
    core_mem_pkg::beat_t        lbuf_rd;
    core_mem_pkg::lbuf_status_t lbuf_stat;

    entry_t      tbl[$];
    logic [31:0] wmem_m [256];
    logic [31:0] cache_m [128];
    logic [31:0] lq[$];                       // Unread LBUF words in arrival order
    int          uoff;                        // Reuse pointer minus read pointer
    int          checks;
    int          errors;
    int          cycles;

    core_mem UUT (
        .clk            (clk),
        .rstn           (rstn),
        .gbus           (gbus),
        .cmem           (cmem),
        .gbus_rd        (gbus_rd),
        .clink_enable   (clink_enable),
        .clink_in       (clink_in),
        .clink_out      (clink_out),
        .lbuf_ren       (lbuf_ren),
        .lbuf_reuse_ren (lbuf_reuse_ren),
        .lbuf_reuse_rst (lbuf_reuse_rst),
        .lbuf_rd        (lbuf_rd),
        .lbuf_stat      (lbuf_stat)
    );

    always #50 clk = ~clk;

    // ==================================================
    // Table building with the scoreboard model
    // ==================================================
    function automatic entry_t new_entry(string name, op_e op);
        entry_t e;
        e.name      = name;
        e.op        = op;
        e.addr      = '0;
        e.data      = '0;
        e.alt       = '0;
        e.en        = 1'b0;
        e.chk       = CHK_NONE;
        e.exp_valid = 1'b0;
        e.exp       = '0;
        return e;
    endfunction

    function automatic core_mem_pkg::core_addr_u make_addr(bit region, int idx);
        core_mem_pkg::core_addr_u a;
        a = '0;
        if (region) begin
            a.cache.region = 1'b1;
            a.cache.idx    = idx[6:0];
        end else begin
            a.wmem.idx = idx[7:0];
        end
        return a;
    endfunction

    task automatic lbuf_accept(logic [31:0] word);
        if (lq.size() < core_mem_pkg::lbuf_depth) begin
            lq.push_back(word);                   // Full buffer drops it
        end
    endtask

    task automatic gbus_write(string name, bit region, int idx);
        entry_t e;
        e      = new_entry(name, OP_GWR);
        e.addr = make_addr(region, idx);
        e.data = $urandom();
        if (region) cache_m[idx] = e.data;
        else        wmem_m[idx]  = e.data;
        tbl.push_back(e);
    endtask

    task automatic gbus_read(string name, bit region, int idx);
        entry_t e;
        e           = new_entry(name, OP_GRD);
        e.addr      = make_addr(region, idx);
        e.chk       = CHK_GBUS;
        e.exp_valid = 1'b1;
        e.exp       = region ? cache_m[idx] : wmem_m[idx];
        tbl.push_back(e);
    endtask

    task automatic cmem_write(string name, int idx);
        entry_t e;
        e            = new_entry(name, OP_CWR);
        e.addr       = make_addr(1'b1, idx);
        e.data       = $urandom();
        cache_m[idx] = e.data;
        tbl.push_back(e);
    endtask

    task automatic collide_write(string name, int idx);
        entry_t e;
        e            = new_entry(name, OP_COLL);
        e.addr       = make_addr(1'b1, idx);
        e.data       = $urandom();
        e.alt        = $urandom();
        cache_m[idx] = e.data;                    // CMEM side wins
        tbl.push_back(e);
    endtask

    task automatic cmem_read(string name, bit region, int idx, bit en);
        entry_t e;
        e           = new_entry(name, OP_CRD);
        e.addr      = make_addr(region, idx);
        e.en        = en;
        e.chk       = CHK_CLINK;
        e.exp_valid = en;
        e.exp       = region ? cache_m[idx] : wmem_m[idx];
        lbuf_accept(e.exp);
        tbl.push_back(e);
    endtask

    task automatic nbr_beat(string name, bit en);
        entry_t e;
        e           = new_entry(name, OP_NBR);
        e.data      = $urandom();
        e.en        = en;
        e.chk       = CHK_CLINK;
        e.exp_valid = en;
        e.exp       = e.data;
        lbuf_accept(e.data);
        tbl.push_back(e);
    endtask

    task automatic lbuf_read(string name);
        entry_t e;
        e           = new_entry(name, OP_LRD);
        e.chk       = CHK_LBUF;
        e.exp_valid = 1'b1;
        e.exp       = lq.pop_front();             // Reuse offset rides along
        tbl.push_back(e);
    endtask

    task automatic reuse_read(string name);
        entry_t e;
        e           = new_entry(name, OP_URD);
        e.chk       = CHK_LBUF;
        e.exp_valid = 1'b1;
        e.exp       = lq[uoff];
        uoff++;
        tbl.push_back(e);
    endtask

    task automatic reuse_rewind(string name);
        entry_t e;
        e    = new_entry(name, OP_URST);
        uoff = 0;
        tbl.push_back(e);
    endtask

    task automatic stat_check(string name);
        entry_t                     e;
        core_mem_pkg::lbuf_status_t s;
        s.empty       = (lq.size() == 0);
        s.reuse_empty = (uoff == lq.size());
        s.full        = (lq.size() == core_mem_pkg::lbuf_depth);
        s.almost_full = (lq.size() >= core_mem_pkg::lbuf_depth - core_mem_pkg::alert_depth);
        e       = new_entry(name, OP_STAT);
        e.chk   = CHK_STAT;
        e.exp   = {28'd0, s};
        tbl.push_back(e);
    endtask

    task automatic build_table();
        gbus_write("wmem_wr_a", 1'b0, 8'h00);
        gbus_write("wmem_wr_b", 1'b0, 8'h5a);
        gbus_write("wmem_wr_c", 1'b0, 8'hff);
        gbus_read("wmem_rd_a", 1'b0, 8'h00);
        gbus_read("wmem_rd_b", 1'b0, 8'h5a);
        gbus_read("wmem_rd_c", 1'b0, 8'hff);
        gbus_write("cache_wr_gbus", 1'b1, 7'h10);
        cmem_write("cache_wr_cmem", 7'h22);
        collide_write("cache_collide", 7'h30);
        gbus_read("cache_rd_gbus", 1'b1, 7'h10);
        gbus_read("cache_rd_cmem", 1'b1, 7'h22);
        gbus_read("cache_rd_collide", 1'b1, 7'h30);
        cmem_read("crd_wmem_on", 1'b0, 8'h5a, 1'b1);
        cmem_read("crd_cache_on", 1'b1, 7'h22, 1'b1);
        cmem_read("crd_wmem_off", 1'b0, 8'hff, 1'b0);
        nbr_beat("nbr_relay", 1'b1);
        for (int i = 0; i < 4; i++) lbuf_read($sformatf("lbuf_drain_%0d", i));
        stat_check("stat_drained");
        // Fill to the brim with some beats from memory
        for (int i = 0; i < 16; i++) begin
            if (i % 4 == 3) begin
                cmem_read($sformatf("fill_crd_%0d", i), i[2], i[2] ? 7'h10 : 8'h5a, 1'b1);
            end else begin
                nbr_beat($sformatf("fill_nbr_%0d", i), 1'b1);
            end
            if (i == 11 || i == 12) stat_check($sformatf("stat_fill_%0d", i + 1));
        end
        stat_check("stat_full");
        nbr_beat("overflow_beat", 1'b1);
        stat_check("stat_after_overflow");
        for (int i = 0; i < 16; i++) lbuf_read($sformatf("fifo_order_%0d", i));
        stat_check("stat_emptied");
        // ==================================================
        // Reuse pass
        // ==================================================
        for (int i = 0; i < 6; i++) nbr_beat($sformatf("reuse_fill_%0d", i), 1'b1);
        reuse_read("reuse_early_0");
        reuse_read("reuse_early_1");
        lbuf_read("reuse_norm_0");
        lbuf_read("reuse_norm_1");
        reuse_rewind("reuse_rst_a");
        for (int i = 0; i < 4; i++) reuse_read($sformatf("reuse_again_%0d", i));
        stat_check("stat_reuse_end");
        reuse_rewind("reuse_rst_b");
        for (int i = 0; i < 4; i++) lbuf_read($sformatf("reuse_tail_%0d", i));
        stat_check("stat_reuse_done");
    endtask

    // ==================================================
    // Drive and check
    // ==================================================
    task automatic drive_op(entry_t e);
        case (e.op)
            OP_GWR: begin
                gbus.addr  <= e.addr;
                gbus.wdata <= e.data;
                gbus.wen   <= 1'b1;
            end
            OP_GRD: begin
                gbus.addr <= e.addr;
                gbus.ren  <= 1'b1;
            end
            OP_CWR: begin
                cmem.waddr <= e.addr;
                cmem.wdata <= e.data;
                cmem.wen   <= 1'b1;
            end
            OP_COLL: begin
                gbus.addr  <= e.addr;
                gbus.wdata <= e.alt;
                gbus.wen   <= 1'b1;
                cmem.waddr <= e.addr;
                cmem.wdata <= e.data;
                cmem.wen   <= 1'b1;
            end
            OP_CRD: begin
                cmem.raddr   <= e.addr;
                cmem.ren     <= 1'b1;
                clink_enable <= e.en;             // Held until the next beat
            end
            OP_NBR: begin
                clink_in     <= '{data: e.data, valid: 1'b1};
                clink_enable <= e.en;
            end
            OP_LRD:  lbuf_ren       <= 1'b1;
            OP_URD:  lbuf_reuse_ren <= 1'b1;
            OP_URST: lbuf_reuse_rst <= 1'b1;
            default: ;
        endcase
    endtask

    task automatic release_strobes();
        gbus.wen       <= 1'b0;
        gbus.ren       <= 1'b0;
        cmem.wen       <= 1'b0;
        cmem.ren       <= 1'b0;
        clink_in.valid <= 1'b0;
        lbuf_ren       <= 1'b0;
        lbuf_reuse_ren <= 1'b0;
        lbuf_reuse_rst <= 1'b0;
    endtask

    task automatic check_beat(string name, core_mem_pkg::beat_t act, bit exp_valid,
                              logic [31:0] exp);
        checks++;
        if (exp_valid) begin
            assert (act.valid === 1'b1 && act.data === exp) else begin
                errors++;
                $display("[FAIL] %s: expected valid=1 data=%h, actual valid=%b data=%h",
                         name, exp, act.valid, act.data);
            end
        end else begin
            assert (act.valid === 1'b0) else begin
                errors++;
                $display("[FAIL] %s: expected valid=0, actual valid=%b", name, act.valid);
            end
        end
    endtask

    task automatic check_entry(entry_t e);
        case (e.chk)
            CHK_GBUS:  check_beat(e.name, gbus_rd, e.exp_valid, e.exp);
            CHK_CLINK: check_beat(e.name, clink_out, e.exp_valid, e.exp);
            CHK_LBUF:  check_beat(e.name, lbuf_rd, e.exp_valid, e.exp);
            CHK_STAT: begin
                checks++;
                assert (lbuf_stat === e.exp[3:0]) else begin
                    errors++;
                    $display("[FAIL] %s: expected flags=%b, actual flags=%b",
                             e.name, e.exp[3:0], lbuf_stat);
                end
            end
            default: ;
        endcase
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4 * tbl.size() + 200) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        gbus           = '0;
        cmem           = '0;
        clink_enable   = 1'b0;
        clink_in       = '0;
        lbuf_ren       = 1'b0;
        lbuf_reuse_ren = 1'b0;
        lbuf_reuse_rst = 1'b0;
        checks         = 0;
        errors         = 0;
        cycles         = 0;
        uoff           = 0;
        void'($urandom(19));
        stat_check("reset_flags");
        build_table();

        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_beat("reset_gbus_rd", gbus_rd, 1'b0, '0);
        check_beat("reset_clink_out", clink_out, 1'b0, '0);
        check_beat("reset_lbuf_rd", lbuf_rd, 1'b0, '0);

        for (int k = 0; k < tbl.size(); k++) begin
            @(posedge clk);
            drive_op(tbl[k]);
            @(posedge clk);
            release_strobes();
            @(negedge clk);
            check_entry(tbl[k]);
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
core_mem_pkg.sv
mem_sp.sv
wmem_port.sv
kv_cache_port.sv
read_return.sv
lbuf_fifo.sv
core_mem.sv
tb_core_mem.sv

// File: wmem_port.sv
`timescale 1ns/1ps

module wmem_port (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_mem_pkg::gbus_req_t   gbus,
    input  core_mem_pkg::cmem_req_t   cmem,
    output core_mem_pkg::mem_rd_t     rd
);

    logic                                  wen;
    logic                                  ren;
    logic                                  gbus_hit;
    logic                                  cmem_hit;
    logic [core_mem_pkg::wmem_addr_w-1:0]  raddr;
    logic [core_mem_pkg::wmem_addr_w-1:0]  addr;
    logic [core_mem_pkg::gbus_data_w-1:0]  rdata;
    logic                                  rvalid_q;

    // Only GBUS loads weights
    assign wen = gbus.wen && !gbus.addr.wmem.region;

    assign gbus_hit = gbus.ren && !gbus.addr.wmem.region;
    assign cmem_hit = cmem.ren && !cmem.raddr.wmem.region;
    assign ren      = gbus_hit || cmem_hit;

    // GBUS read owns the port over CMEM
    assign raddr = gbus_hit ? gbus.addr.wmem.idx : cmem.raddr.wmem.idx;
    assign addr  = wen ? gbus.addr.wmem.idx : raddr;     // Write wins the address

    mem_sp #(
        .depth (core_mem_pkg::wmem_depth)
    ) u_wmem (
        .clk   (clk),
        .addr  (addr),
        .wen   (wen),
        .wdata (gbus.wdata),
        .ren   (ren),
        .rdata (rdata)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= ren;
        end
    end

    assign rd = '{rdata: rdata, rvalid: rvalid_q};

    // Single port, so a read beside a write would return stale data
    a_no_wr_rd_collide: assert property (
        @(posedge clk) disable iff (!rstn) !(wen && ren)
    ) else $error("wmem_port: write and read of WMEM in one cycle");

endmodule
